// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_pipe_ctrl
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
design/rv_ctrl_pkg.sv
design/fetch_stage.sv
design/instr_decoder.sv
design/id_ex_reg.sv
design/mem_wb_ctrl.sv
design/pipe_ctrl_top.sv
test/pipe_ctrl_chk.sv
test/tb_pipe_ctrl.sv

// File: design/fetch_stage.sv
// Fetch stage with PC register, byte-wide instruction ROM and IF/ID register
`timescale 1ns/1ns

module fetch_stage import rv_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            load_en,
    input  imem_word_addr_t load_addr,
    input  word_t           load_data,
    output word_t           if_pc,
    output word_t           id_instr,
    output word_t           id_pc
);

    logic [7:0]      mem [IMEM_BYTES];
    imem_byte_addr_t rd_addr;
    word_t           fetch_instr;
    word_t           pc_plus4;

    assign pc_plus4 = if_pc + 32'd4;
    assign rd_addr  = if_pc[8:0];  // ROM wraps at 512 bytes

    // Little-endian word assembly
    assign fetch_instr = {mem[rd_addr + 9'd3], mem[rd_addr + 9'd2],
                          mem[rd_addr + 9'd1], mem[rd_addr]};

    // Program load with the low byte at the lowest address
    always_ff @(posedge clk) begin
        if (load_en) begin
            for (int i = 0; i < 4; i++) begin
                mem[{load_addr, 2'(i)}] <= load_data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_pc <= '0;
        end else if (!stall) begin
            if_pc <= pc_plus4;  // No redirect in this front end
        end
    end

    // IF/ID holds its contents while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            id_instr <= '0;
            id_pc    <= '0;
        end else if (!stall) begin
            id_instr <= fetch_instr;
            id_pc    <= if_pc;
        end
    end

endmodule

// File: design/id_ex_reg.sv
// ID/EX register with bubble insertion under stall
`timescale 1ns/1ns

module id_ex_reg import rv_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  word_t     id_pc,
    input  alu_op_t   id_alu_op,
    input  imm_sel_t  id_imm_sel,
    input  logic      id_rf_enable,
    input  logic      id_load_inst,
    input  logic      id_mem_enable,
    input  logic      id_mem_write,
    input  logic      id_se,
    input  mem_size_t id_size,
    input  cond_t     id_cond,
    input  logic      id_jalr,
    input  logic      id_jal,
    input  logic      id_auipc,
    output word_t     ex_pc,
    output alu_op_t   ex_alu_op,
    output imm_sel_t  ex_imm_sel,
    output logic      ex_rf_enable,
    output logic      ex_load_inst,
    output logic      ex_mem_enable,
    output logic      ex_mem_write,
    output logic      ex_se,
    output mem_size_t ex_size,
    output cond_t     ex_cond,
    output logic      ex_jalr,
    output logic      ex_jal,
    output logic      ex_auipc
);

    always_ff @(posedge clk) begin
        if (reset || stall) begin  // Stall loads a NOP bubble
            ex_pc         <= '0;
            ex_alu_op     <= '0;
            ex_imm_sel    <= '0;
            ex_rf_enable  <= 1'b0;
            ex_load_inst  <= 1'b0;
            ex_mem_enable <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_se         <= 1'b0;
            ex_size       <= '0;
            ex_cond       <= '0;
            ex_jalr       <= 1'b0;
            ex_jal        <= 1'b0;
            ex_auipc      <= 1'b0;
        end else begin
            ex_pc         <= id_pc;
            ex_alu_op     <= id_alu_op;
            ex_imm_sel    <= id_imm_sel;
            ex_rf_enable  <= id_rf_enable;
            ex_load_inst  <= id_load_inst;
            ex_mem_enable <= id_mem_enable;
            ex_mem_write  <= id_mem_write;
            ex_se         <= id_se;
            ex_size       <= id_size;
            ex_cond       <= id_cond;
            ex_jalr       <= id_jalr;
            ex_jal        <= id_jal;
            ex_auipc      <= id_auipc;
        end
    end

endmodule

// File: design/instr_decoder.sv
// Combinational RV32I decoder producing the pipeline control word
`timescale 1ns/1ns

module instr_decoder import rv_ctrl_pkg::*; (
    input  word_t     instr,
    output alu_op_t   id_alu_op,
    output imm_sel_t  id_imm_sel,
    output logic      id_rf_enable,
    output logic      id_load_inst,
    output logic      id_mem_enable,
    output logic      id_mem_write,
    output logic      id_se,
    output mem_size_t id_size,
    output cond_t     id_cond,
    output logic      id_jalr,
    output logic      id_jal,
    output logic      id_auipc
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];  // SUB and SRA select

    // Register and immediate arithmetic share one funct3 table
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_bit,
                                         input logic sub_ok);
        alu_op_t op;
        case (f3)
            3'b000:  op = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        id_alu_op     = ALU_PASS;
        id_imm_sel    = IMM_NONE;
        id_rf_enable  = 1'b0;
        id_load_inst  = 1'b0;
        id_mem_enable = 1'b0;
        id_mem_write  = 1'b0;
        id_se         = 1'b0;
        id_size       = SIZE_BYTE;
        id_cond       = '0;
        id_jalr       = 1'b0;
        id_jal        = 1'b0;
        id_auipc      = 1'b0;

        case (opcode)
            OP_R: begin
                id_alu_op    = arith_op(funct3, alt, 1'b1);
                id_rf_enable = 1'b1;
            end
            OP_I: begin
                id_alu_op    = arith_op(funct3, alt, 1'b0);  // No SUBI
                id_imm_sel   = IMM_I;
                id_rf_enable = 1'b1;
            end
            OP_LOAD: begin
                id_alu_op     = ALU_ADD;  // Address computation
                id_imm_sel    = IMM_I;
                id_rf_enable  = 1'b1;
                id_load_inst  = 1'b1;
                id_mem_enable = 1'b1;
                id_size       = mem_size_t'(funct3[1:0]);
                id_se         = (funct3 == 3'b000) || (funct3 == 3'b001);  // LB, LH
            end
            OP_STORE: begin
                id_alu_op     = ALU_ADD;
                id_imm_sel    = IMM_S;
                id_mem_enable = 1'b1;
                id_mem_write  = 1'b1;
                id_size       = mem_size_t'(funct3[1:0]);
            end
            OP_BRANCH: begin
                id_cond = {opcode, funct3};
                case (funct3)
                    3'b000, 3'b001: id_alu_op = ALU_SUB;   // BEQ, BNE
                    3'b100, 3'b101: id_alu_op = ALU_SLT;   // BLT, BGE
                    3'b110, 3'b111: id_alu_op = ALU_SLTU;  // BLTU, BGEU
                    default:        id_alu_op = ALU_PASS;
                endcase
            end
            OP_JALR: begin
                id_alu_op    = ALU_JALR;
                id_imm_sel   = IMM_I;
                id_rf_enable = 1'b1;
                id_jalr      = 1'b1;
            end
            OP_JAL: begin
                id_rf_enable = 1'b1;
                id_jal       = 1'b1;
            end
            OP_LUI: begin
                id_alu_op    = ALU_PASS;
                id_imm_sel   = IMM_U;
                id_rf_enable = 1'b1;
            end
            OP_AUIPC: begin
                id_alu_op    = ALU_ADD;
                id_imm_sel   = IMM_U;
                id_rf_enable = 1'b1;
                id_auipc     = 1'b1;
            end
            default: ;  // Unknown opcode or all-zero word
        endcase
    end

endmodule

// File: design/mem_wb_ctrl.sv
// EX/MEM and MEM/WB control registers for the back half of the pipeline
`timescale 1ns/1ns

module mem_wb_ctrl import rv_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_rf_enable,
    input  logic      ex_load_inst,
    input  logic      ex_mem_enable,
    input  logic      ex_mem_write,
    input  logic      ex_se,
    input  mem_size_t ex_size,
    output logic      mem_rf_enable,
    output logic      mem_load_inst,
    output logic      mem_mem_enable,
    output logic      mem_mem_write,
    output logic      mem_se,
    output mem_size_t mem_size,
    output logic      wb_rf_enable
);

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rf_enable  <= 1'b0;
            mem_load_inst  <= 1'b0;
            mem_mem_enable <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_se         <= 1'b0;
            mem_size       <= '0;
        end else begin
            mem_rf_enable  <= ex_rf_enable;
            mem_load_inst  <= ex_load_inst;
            mem_mem_enable <= ex_mem_enable;
            mem_mem_write  <= ex_mem_write;
            mem_se         <= ex_se;
            mem_size       <= ex_size;
        end
    end

    // MEM/WB keeps only the writeback enable
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_rf_enable <= 1'b0;
        end else begin
            wb_rf_enable <= mem_rf_enable;
        end
    end

endmodule

// File: design/pipe_ctrl_top.sv
// Top level of the RV32I control pipeline from fetch to writeback
`timescale 1ns/1ns

module pipe_ctrl_top import rv_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            load_en,
    input  imem_word_addr_t load_addr,
    input  word_t           load_data,
    output word_t           if_pc,
    output word_t           ex_pc,
    output alu_op_t         ex_alu_op,
    output imm_sel_t        ex_imm_sel,
    output logic            ex_rf_enable,
    output logic            ex_load_inst,
    output logic            ex_mem_enable,
    output logic            ex_mem_write,
    output logic            ex_se,
    output mem_size_t       ex_size,
    output cond_t           ex_cond,
    output logic            ex_jalr,
    output logic            ex_jal,
    output logic            ex_auipc,
    output logic            mem_rf_enable,
    output logic            mem_load_inst,
    output logic            mem_mem_enable,
    output logic            mem_mem_write,
    output mem_size_t       mem_size,
    output logic            mem_se,
    output logic            wb_rf_enable
);

    word_t     id_instr;
    word_t     id_pc;
    alu_op_t   id_alu_op;
    imm_sel_t  id_imm_sel;
    logic      id_rf_enable;
    logic      id_load_inst;
    logic      id_mem_enable;
    logic      id_mem_write;
    logic      id_se;
    mem_size_t id_size;
    cond_t     id_cond;
    logic      id_jalr;
    logic      id_jal;
    logic      id_auipc;

    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .if_pc     (if_pc),
        .id_instr  (id_instr),
        .id_pc     (id_pc)
    );

    instr_decoder u_decoder (
        .instr         (id_instr),
        .id_alu_op     (id_alu_op),
        .id_imm_sel    (id_imm_sel),
        .id_rf_enable  (id_rf_enable),
        .id_load_inst  (id_load_inst),
        .id_mem_enable (id_mem_enable),
        .id_mem_write  (id_mem_write),
        .id_se         (id_se),
        .id_size       (id_size),
        .id_cond       (id_cond),
        .id_jalr       (id_jalr),
        .id_jal        (id_jal),
        .id_auipc      (id_auipc)
    );

    id_ex_reg u_id_ex (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .id_pc         (id_pc),
        .id_alu_op     (id_alu_op),
        .id_imm_sel    (id_imm_sel),
        .id_rf_enable  (id_rf_enable),
        .id_load_inst  (id_load_inst),
        .id_mem_enable (id_mem_enable),
        .id_mem_write  (id_mem_write),
        .id_se         (id_se),
        .id_size       (id_size),
        .id_cond       (id_cond),
        .id_jalr       (id_jalr),
        .id_jal        (id_jal),
        .id_auipc      (id_auipc),
        .ex_pc         (ex_pc),
        .ex_alu_op     (ex_alu_op),
        .ex_imm_sel    (ex_imm_sel),
        .ex_rf_enable  (ex_rf_enable),
        .ex_load_inst  (ex_load_inst),
        .ex_mem_enable (ex_mem_enable),
        .ex_mem_write  (ex_mem_write),
        .ex_se         (ex_se),
        .ex_size       (ex_size),
        .ex_cond       (ex_cond),
        .ex_jalr       (ex_jalr),
        .ex_jal        (ex_jal),
        .ex_auipc      (ex_auipc)
    );

    mem_wb_ctrl u_mem_wb (
        .clk            (clk),
        .reset          (reset),
        .ex_rf_enable   (ex_rf_enable),
        .ex_load_inst   (ex_load_inst),
        .ex_mem_enable  (ex_mem_enable),
        .ex_mem_write   (ex_mem_write),
        .ex_se          (ex_se),
        .ex_size        (ex_size),
        .mem_rf_enable  (mem_rf_enable),
        .mem_load_inst  (mem_load_inst),
        .mem_mem_enable (mem_mem_enable),
        .mem_mem_write  (mem_mem_write),
        .mem_se         (mem_se),
        .mem_size       (mem_size),
        .wb_rf_enable   (wb_rf_enable)
    );

endmodule

// File: design/rv_ctrl_pkg.sv
// Shared widths, control field types and encodings for the RV32I control pipeline
package rv_ctrl_pkg;

    typedef logic [31:0] word_t;            // Instruction or PC value
    typedef logic [8:0]  imem_byte_addr_t;  // Byte address into the ROM
    typedef logic [6:0]  imem_word_addr_t;  // Word index for the load port

    localparam int IMEM_BYTES = 512;

    // ALU operation codes
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_PASS = 4'b0000;
    localparam alu_op_t ALU_ADD  = 4'b0010;
    localparam alu_op_t ALU_SUB  = 4'b0011;
    localparam alu_op_t ALU_JALR = 4'b0100;
    localparam alu_op_t ALU_SLL  = 4'b0101;
    localparam alu_op_t ALU_SRL  = 4'b0110;
    localparam alu_op_t ALU_SRA  = 4'b0111;
    localparam alu_op_t ALU_SLT  = 4'b1000;
    localparam alu_op_t ALU_SLTU = 4'b1001;
    localparam alu_op_t ALU_AND  = 4'b1010;
    localparam alu_op_t ALU_OR   = 4'b1011;
    localparam alu_op_t ALU_XOR  = 4'b1100;

    // Second operand source
    typedef logic [2:0] imm_sel_t;

    localparam imm_sel_t IMM_NONE = 3'b000;
    localparam imm_sel_t IMM_I    = 3'b001;
    localparam imm_sel_t IMM_S    = 3'b010;
    localparam imm_sel_t IMM_U    = 3'b011;

    // Data memory access size
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'b00;
    localparam mem_size_t SIZE_HALF = 2'b01;
    localparam mem_size_t SIZE_WORD = 2'b10;

    typedef logic [9:0] cond_t;  // {opcode, funct3} of a branch

    // Major opcodes, instr[6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

endpackage

// File: test/pipe_ctrl_chk.sv
// Bound checker for PC stepping, stall bubbles and writeback enable propagation
`timescale 1ns/1ns

module pipe_ctrl_chk import rv_ctrl_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input word_t       if_pc,
    input word_t       ex_pc,
    input logic [26:0] ex_word,  // Full ex_* control word
    input logic        mem_rf_enable,
    input logic        wb_rf_enable
);

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(stall) |-> if_pc == $past(if_pc) + 32'd4)
        else $error("if_pc did not step by 4");

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && $past(stall) |-> if_pc == $past(if_pc))
        else $error("if_pc moved while stalled");

    assert property (@(posedge clk) disable iff (reset)
        $past(stall) |-> ex_word == '0 && ex_pc == '0)
        else $error("ID/EX did not take a bubble under stall");

    // MEM/WB carries the write enable one cycle later
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> wb_rf_enable == $past(mem_rf_enable))
        else $error("wb_rf_enable does not follow mem_rf_enable");

endmodule

bind pipe_ctrl_top pipe_ctrl_chk chk0 (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .if_pc         (if_pc),
    .ex_pc         (ex_pc),
    .ex_word       ({ex_alu_op, ex_imm_sel, ex_rf_enable, ex_load_inst, ex_mem_enable,
                     ex_mem_write, ex_se, ex_size, ex_cond, ex_jalr, ex_jal, ex_auipc}),
    .mem_rf_enable (mem_rf_enable),
    .wb_rf_enable  (wb_rf_enable)
);

// File: test/tb_pipe_ctrl.sv
// Testbench checking the RV32I control pipeline against a cycle-level reference model
`timescale 1ns/1ns

module tb_pipe_ctrl import rv_ctrl_pkg::*; ();

    typedef logic [26:0] ctl_t;  // {alu, imm, rf, ld, men, mw, se, size, cond, jalr, jal, auipc}

    localparam int R_BASE     = 4;
    localparam int I_BASE     = 14;
    localparam int LS_BASE    = 23;
    localparam int BJ_BASE    = 33;
    localparam int WAIT_LIMIT = 300;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            load_en;
    imem_word_addr_t load_addr;
    word_t           load_data;
    word_t           if_pc;
    word_t           ex_pc;
    alu_op_t         ex_alu_op;
    imm_sel_t        ex_imm_sel;
    logic            ex_rf_enable;
    logic            ex_load_inst;
    logic            ex_mem_enable;
    logic            ex_mem_write;
    logic            ex_se;
    mem_size_t       ex_size;
    cond_t           ex_cond;
    logic            ex_jalr;
    logic            ex_jal;
    logic            ex_auipc;
    logic            mem_rf_enable;
    logic            mem_load_inst;
    logic            mem_mem_enable;
    logic            mem_mem_write;
    logic            mem_se;
    mem_size_t       mem_size;
    logic            wb_rf_enable;

    ctl_t       ex_ctl;
    logic [6:0] mem_ctl;
    word_t      prog [128];
    word_t      rng;

    // Expected pipeline contents
    word_t m_if_pc;
    word_t m_id_pc;
    word_t m_id_instr;
    word_t m_ex_pc;
    ctl_t  m_ex;
    ctl_t  m_mem;
    logic  m_wb;

    pipe_ctrl_top dut0 (.*);

    assign ex_ctl  = {ex_alu_op, ex_imm_sel, ex_rf_enable, ex_load_inst, ex_mem_enable,
                      ex_mem_write, ex_se, ex_size, ex_cond, ex_jalr, ex_jal, ex_auipc};
    assign mem_ctl = {mem_rf_enable, mem_load_inst, mem_mem_enable, mem_mem_write,
                      mem_se, mem_size};

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [6:0] rand_f7();
        word_t r;
        r = next_rand();
        return r[31:25];
    endfunction

    function automatic word_t build_instr(input logic [6:0] f7, input logic [2:0] f3,
                                          input opcode_t op);
        word_t r;
        r = next_rand();
        return {f7, r[9:0], f3, r[14:10], op};  // Random rs2, rs1 and rd
    endfunction

    function automatic word_t word_addr(input int idx);
        return word_t'(idx * 4);
    endfunction

    // Arithmetic code for R and I groups from funct3 and bit 30
    function automatic alu_op_t arith_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic ctl_t ref_decode(input word_t w);
        alu_op_t    alu;
        imm_sel_t   imm;
        logic [6:0] flags;  // rf, ld, men, mw, se, size
        cond_t      cond;
        logic [2:0] jumps;  // jalr, jal, auipc
        logic [2:0] f3;
        f3    = w[14:12];
        alu   = ALU_PASS;
        imm   = IMM_NONE;
        flags = '0;
        cond  = '0;
        jumps = '0;
        case (w[6:0])
            OP_R: begin
                alu   = arith_code(f3, w[30]);
                flags = 7'b1000000;
            end
            OP_I: begin
                alu   = (f3 == 3'b000) ? ALU_ADD : arith_code(f3, w[30]);
                imm   = IMM_I;
                flags = 7'b1000000;
            end
            OP_LOAD: begin
                alu   = ALU_ADD;
                imm   = IMM_I;
                flags = {3'b111, 1'b0, (f3[2:1] == 2'b00), f3[1:0]};
            end
            OP_STORE: begin
                alu   = ALU_ADD;
                imm   = IMM_S;
                flags = {2'b00, 2'b11, 1'b0, f3[1:0]};
            end
            OP_BRANCH: begin
                cond = {w[6:0], f3};
                case (f3[2:1])
                    2'b00:   alu = ALU_SUB;
                    2'b10:   alu = ALU_SLT;
                    2'b11:   alu = ALU_SLTU;
                    default: alu = ALU_PASS;
                endcase
            end
            OP_JALR: begin
                alu   = ALU_JALR;
                imm   = IMM_I;
                flags = 7'b1000000;
                jumps = 3'b100;
            end
            OP_JAL: begin
                flags = 7'b1000000;
                jumps = 3'b010;
            end
            OP_LUI: begin
                imm   = IMM_U;
                flags = 7'b1000000;
            end
            OP_AUIPC: begin
                alu   = ALU_ADD;
                imm   = IMM_U;
                flags = 7'b1000000;
                jumps = 3'b001;
            end
            default: ;
        endcase
        return {alu, imm, flags, cond, jumps};
    endfunction

    task automatic build_program();
        logic [2:0] f3v;
        for (int i = 0; i < 128; i++) begin
            prog[7'(i)] = next_rand();  // Background words
        end
        for (int i = 0; i < 8; i++) begin
            f3v = 3'(i);
            prog[7'(R_BASE + i)] = build_instr(7'b0000000, f3v, OP_R);
            if (f3v == 3'b001 || f3v == 3'b101) begin
                prog[7'(I_BASE + i)] = build_instr(7'b0000000, f3v, OP_I);
            end else begin
                // ADDI with bit 30 set still decodes as ADD
                prog[7'(I_BASE + i)] = build_instr(rand_f7() | 7'b0100000, f3v, OP_I);
            end
        end
        prog[7'(R_BASE + 8)]  = build_instr(7'b0100000, 3'b000, OP_R);     // SUB
        prog[7'(R_BASE + 9)]  = build_instr(7'b0100000, 3'b101, OP_R);     // SRA
        prog[7'(I_BASE + 8)]  = build_instr(7'b0100000, 3'b101, OP_I);     // SRAI
        prog[7'(LS_BASE + 0)] = build_instr(rand_f7(), 3'b000, OP_LOAD);   // LB
        prog[7'(LS_BASE + 1)] = build_instr(rand_f7(), 3'b001, OP_LOAD);   // LH
        prog[7'(LS_BASE + 2)] = build_instr(rand_f7(), 3'b010, OP_LOAD);   // LW
        prog[7'(LS_BASE + 3)] = build_instr(rand_f7(), 3'b100, OP_LOAD);   // LBU
        prog[7'(LS_BASE + 4)] = build_instr(rand_f7(), 3'b101, OP_LOAD);   // LHU
        for (int i = 0; i < 3; i++) begin
            prog[7'(LS_BASE + 5 + i)] = build_instr(rand_f7(), 3'(i), OP_STORE);
        end
        for (int j = 0; j < 6; j++) begin
            f3v = (j < 2) ? 3'(j) : 3'(j + 2);  // BEQ BNE BLT BGE BLTU BGEU
            prog[7'(BJ_BASE + j)] = build_instr(rand_f7(), f3v, OP_BRANCH);
        end
        prog[7'(BJ_BASE + 6)]  = build_instr(rand_f7(), 3'b000, OP_JALR);
        prog[7'(BJ_BASE + 7)]  = build_instr(rand_f7(), 3'b011, OP_JAL);
        prog[7'(BJ_BASE + 8)]  = build_instr(rand_f7(), 3'b110, OP_LUI);
        prog[7'(BJ_BASE + 9)]  = build_instr(rand_f7(), 3'b001, OP_AUIPC);
        prog[7'(BJ_BASE + 10)] = '0;
        prog[7'(BJ_BASE + 11)] = build_instr(rand_f7(), 3'b000, 7'b1111111);  // Unknown opcode
    endtask

    task automatic compare(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_outputs();
        compare("if_pc", if_pc, m_if_pc);
        compare("ex_pc", ex_pc, m_ex_pc);
        compare("ex_alu_op", 32'(ex_ctl[26:23]), 32'(m_ex[26:23]));
        compare("ex_imm_sel", 32'(ex_ctl[22:20]), 32'(m_ex[22:20]));
        compare("ex rf/mem/se/size", 32'(ex_ctl[19:13]), 32'(m_ex[19:13]));
        compare("ex_cond", 32'(ex_ctl[12:3]), 32'(m_ex[12:3]));
        compare("ex jalr/jal/auipc", 32'(ex_ctl[2:0]), 32'(m_ex[2:0]));
        compare("mem_* fields", 32'(mem_ctl), 32'(m_mem[19:13]));
        compare("wb_rf_enable", 32'(wb_rf_enable), 32'(m_wb));
    endtask

    // Advance the model by one clock and check every output
    task automatic tick();
        logic s;
        s = stall;  // Value seen by the coming edge
        @(negedge clk);
        m_wb  = m_mem[19];
        m_mem = m_ex;
        if (s) begin
            m_ex    = '0;
            m_ex_pc = '0;
        end else begin
            m_ex       = ref_decode(m_id_instr);
            m_ex_pc    = m_id_pc;
            m_id_instr = prog[m_if_pc[8:2]];
            m_id_pc    = m_if_pc;
            m_if_pc    = m_if_pc + 32'd4;
        end
        check_outputs();
    endtask

    task automatic run_until_ex_pc(input word_t addr);
        int n;
        n = 0;
        while (ex_pc !== addr) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: ex_pc never reached 0x%0h", addr);
                $display("STATUS: FAIL");
                $fatal(1, "Wait timed out");
            end
            tick();
            n++;
        end
    endtask

    task automatic reset_fetch_test();
        check_outputs();
        compare("if_pc after reset", if_pc, 32'd0);
        repeat (3) tick();
        compare("if_pc after three cycles", if_pc, 32'd12);
    endtask

    task automatic arith_decode_test();
        run_until_ex_pc(word_addr(R_BASE + 8));
        compare("ex_alu_op of SUB", 32'(ex_alu_op), 32'(ALU_SUB));
        run_until_ex_pc(word_addr(R_BASE + 9));
        compare("ex_alu_op of SRA", 32'(ex_alu_op), 32'(ALU_SRA));
        run_until_ex_pc(word_addr(I_BASE + 8));
        compare("ex_alu_op of SRAI", 32'(ex_alu_op), 32'(ALU_SRA));
        compare("ex_imm_sel of SRAI", 32'(ex_imm_sel), 32'(IMM_I));
    endtask

    task automatic load_store_test();
        run_until_ex_pc(word_addr(LS_BASE));  // LB
        compare("ex_se of LB", 32'(ex_se), 32'd1);
        compare("ex_size of LB", 32'(ex_size), 32'(SIZE_BYTE));
        tick();
        compare("mem_load_inst of LB", 32'(mem_load_inst), 32'd1);
        compare("mem_se of LB", 32'(mem_se), 32'd1);
        tick();
        compare("wb_rf_enable of LB", 32'(wb_rf_enable), 32'd1);
        run_until_ex_pc(word_addr(LS_BASE + 7));  // SW
        compare("ex_mem_write of SW", 32'(ex_mem_write), 32'd1);
        compare("ex_size of SW", 32'(ex_size), 32'(SIZE_WORD));
        tick();
        compare("mem_mem_write of SW", 32'(mem_mem_write), 32'd1);
        tick();
        compare("wb_rf_enable of SW", 32'(wb_rf_enable), 32'd0);
    endtask

    task automatic branch_jump_test();
        run_until_ex_pc(word_addr(BJ_BASE));
        compare("ex_cond of BEQ", 32'(ex_cond), 32'({OP_BRANCH, 3'b000}));
        run_until_ex_pc(word_addr(BJ_BASE + 6));
        compare("ex_jalr of JALR", 32'(ex_jalr), 32'd1);
        run_until_ex_pc(word_addr(BJ_BASE + 10));
        compare("ex control of zero word", 32'(ex_ctl), 32'd0);
        run_until_ex_pc(word_addr(BJ_BASE + 11));
        compare("ex control of unknown opcode", 32'(ex_ctl), 32'd0);
    endtask

    task automatic stall_test();
        word_t held_pc;
        held_pc = if_pc;
        stall   = 1'b1;
        repeat (4) begin
            tick();
            compare("if_pc under stall", if_pc, held_pc);
            compare("ex control under stall", 32'(ex_ctl), 32'd0);
        end
        stall = 1'b0;
        tick();
        compare("ex_pc of held instruction", ex_pc, held_pc - 32'd4);
        tick();
        compare("ex_pc after release", ex_pc, held_pc);
        run_until_ex_pc(held_pc + 32'd32);
    endtask

    initial begin
        reset      = 1'b1;
        stall      = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        rng        = 32'd86370;
        m_if_pc    = '0;
        m_id_pc    = '0;
        m_id_instr = '0;
        m_ex_pc    = '0;
        m_ex       = '0;
        m_mem      = '0;
        m_wb       = 1'b0;
        build_program();
        // Program goes in while reset is held
        for (int i = 0; i < 128; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = 7'(i);
            load_data = prog[7'(i)];
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        reset_fetch_test();
        arith_decode_test();
        load_store_test();
        branch_jump_test();
        stall_test();
        repeat (2) tick();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
